/* common/vec_alu_settings.svh */
// Vector ALU build settings for data width, mask width and opcode width
`ifndef VEC_ALU_SETTINGS_SVH
`define VEC_ALU_SETTINGS_SVH

// --------------------------------------------------
// datapath geometry
// --------------------------------------------------
// one 64-bit register chunk per request
`define VEC_XLEN   64
// one enable bit per element, up to 8 byte elements
`define VEC_MASK_W 8

// opcode field, 14 codes in use
`define VEC_OP_W   4

`endif

/* common/vec_op_pkg.sv */
// opcode, op class and pipeline payload types of the vector ALU
`include "vec_alu_settings.svh"

package vec_op_pkg;

    // --------------------------------------------------
    // opcodes
    // --------------------------------------------------
    typedef enum logic [`VEC_OP_W-1:0] {
        OP_MV   = 4'd0,   // copy opa
        OP_ADD  = 4'd1,   // vs2 + opa
        OP_SUB  = 4'd2,   // vs2 - opa
        OP_RSUB = 4'd3,   // opa - vs2
        OP_MAXU = 4'd4,
        OP_MAX  = 4'd5,
        OP_MINU = 4'd6,
        OP_MIN  = 4'd7,
        OP_SLL  = 4'd8,
        OP_SRL  = 4'd9,
        OP_SRA  = 4'd10,
        OP_AND  = 4'd11,
        OP_OR   = 4'd12,
        OP_XOR  = 4'd13   // 14 and 15 unused
    } op_t;

    // which lane produces the result
    typedef enum logic [1:0] {
        CLS_NONE  = 2'd0,  // undefined opcode, result 0
        CLS_ARITH = 2'd1,
        CLS_SHLOG = 2'd2
    } op_class_t;

    // --------------------------------------------------
    // payloads
    // --------------------------------------------------
    typedef struct packed {
        op_t                      op;
        vec_types_pkg::ew_t       sew;
        vec_types_pkg::vec_data_t vs1;
        logic                     rs1_valid;  // use rs1 instead of vs1
        logic [`VEC_XLEN-1:0]     rs1;        // scalar, low element bits used
        vec_types_pkg::vec_data_t vs2;
        vec_types_pkg::vec_data_t wr_old;     // kept in disabled elements
        logic [`VEC_MASK_W-1:0]   en_mask;
    } vec_alu_req_t;

    typedef struct packed {
        op_t                      op;
        op_class_t                cls;
        vec_types_pkg::ew_t       sew;
        vec_types_pkg::vec_data_t opa;        // vs1 or splatted rs1
        vec_types_pkg::vec_data_t vs2;
        vec_types_pkg::vec_data_t wr_old;
        logic [`VEC_MASK_W-1:0]   en_mask;
    } vec_operands_t;

endpackage

/* common/vec_types_pkg.sv */
// element width codes and the multi-view data word of the vector ALU
`include "vec_alu_settings.svh"

package vec_types_pkg;

    // --------------------------------------------------
    // element width
    // --------------------------------------------------
    // all four codes are legal, no width is left undefined
    typedef enum logic [1:0] {
        EW8  = 2'd0,  // 8 elements of 8 bits
        EW16 = 2'd1,  // 4 elements of 16 bits
        EW32 = 2'd2,  // 2 elements of 32 bits
        EW64 = 2'd3   // one element of 64 bits
    } ew_t;

    // --------------------------------------------------
    // data word
    // --------------------------------------------------
    // The same 64 bits read as 1, 2, 4 or 8 elements. Element 0 sits in the
    // low bits in every view, so mask bit e always selects the same element
    // index whatever the width.
    typedef union packed {
        logic [0:0][`VEC_XLEN-1:0]                   w64;  // whole word
        logic [1:0][`VEC_XLEN/2-1:0]                 w32;  // two words
        logic [3:0][`VEC_XLEN/4-1:0]                 w16;  // four halves
        logic [`VEC_MASK_W-1:0][`VEC_XLEN/`VEC_MASK_W-1:0] w8;  // eight bytes
    } vec_data_t;

    // element bits per view
    //   w8  -> [7:0]
    //   w16 -> [15:0]
    //   w32 -> [31:0]
    //   w64 -> [63:0]

endpackage

/* test/vec_alu_model.svh */
// reference model of the vector ALU result and the value compare of its testbench
`ifndef VEC_ALU_MODEL_SVH
`define VEC_ALU_MODEL_SVH

// --------------------------------------------------
// expected result, one element at a time
// --------------------------------------------------
function automatic logic [63:0] model_result(input vec_alu_req_t req);
    int                 ebits;
    int                 sh;
    logic [63:0]        emask;
    logic [63:0]        a;
    logic [63:0]        b;
    logic [63:0]        r;
    logic [63:0]        res;
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    ebits = 8 << req.sew;
    sh    = 64 - ebits;                 // pad above the element
    emask = {64{1'b1}} >> sh;
    res   = '0;
    for (int e = 0; e < 64 / ebits; e++) begin
        if (req.rs1_valid)
            a = req.rs1 & emask;        // same scalar in every element
        else
            a = (req.vs1 >> (e * ebits)) & emask;
        b  = (req.vs2 >> (e * ebits)) & emask;
        sa = $signed(a << sh) >>> sh;   // sign-extended element
        sb = $signed(b << sh) >>> sh;
        case (req.op)
            OP_MV:   r = a;
            OP_ADD:  r = b + a;
            OP_SUB:  r = b - a;
            OP_RSUB: r = a - b;
            OP_MAXU: r = (a > b) ? a : b;
            OP_MAX:  r = (sa > sb) ? a : b;
            OP_MINU: r = (a < b) ? a : b;
            OP_MIN:  r = (sa < sb) ? a : b;
            OP_SLL:  r = b << (a & (ebits - 1));
            OP_SRL:  r = b >> (a & (ebits - 1));
            OP_SRA:  r = sb >>> (a & (ebits - 1));
            OP_AND:  r = b & a;
            OP_OR:   r = b | a;
            OP_XOR:  r = b ^ a;
            default: r = '0;            // codes 14 and 15
        endcase
        if (!req.en_mask[e])
            r = req.wr_old >> (e * ebits);
        res = res | ((r & emask) << (e * ebits));
    end
    return res;
endfunction

task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (act !== exp) begin
        $display("Error %s: expected %h, actual %h", name, exp, act);
        err_value++;
    end
endtask

`endif

/* test/tb_vec_alu.sv */
// testbench of the vector ALU with random requests checked against a reference model
`timescale 1ns/1ps
`include "vec_alu_settings.svh"

module tb_vec_alu;
    import vec_types_pkg::*;
    import vec_op_pkg::*;

    localparam int RESET_CYCLES = 8;
    localparam int PHASE_CYCLES = 160;
    localparam int NUM_PHASES   = 5;
    localparam int CYCLE_LIMIT  = NUM_PHASES * PHASE_CYCLES + RESET_CYCLES + 20;

    logic         i_clk;
    logic         i_reset;
    logic         i_valid;
    vec_alu_req_t i_req;
    logic         o_valid;
    vec_data_t    o_res;

    integer       seed      = 20;
    int           err_value = 0;
    int           err_other = 0;
    int           cycle_cnt = 0;
    logic         valid_d1  = 1'b0;  // i_valid history for the latency check
    logic         valid_d2  = 1'b0;
    logic [63:0]  exp_q[$];
    string        name_q[$];

    `include "vec_alu_model.svh"

    vec_alu_top vec_alu_top_inst (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_valid (i_valid),
        .i_req   (i_req),
        .o_valid (o_valid),
        .o_res   (o_res)
    );

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    function automatic int unsigned pick(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic [63:0] rand64();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic string phase_name(input int p);
        case (p)
            0:       return "arith_full_mask";
            1:       return "shift_logic_full_mask";
            2:       return "scalar_splat";
            3:       return "random_mask";
            default: return "mixed_gaps";
        endcase
    endfunction

    // --------------------------------------------------
    // request generation per phase
    // --------------------------------------------------
    task automatic make_req(input int p, output logic valid, output vec_alu_req_t req);
        int unsigned k;
        req.sew       = ew_t'(2'(pick(4)));
        req.vs1       = rand64();
        req.rs1       = rand64();
        req.vs2       = rand64();
        req.wr_old    = rand64();
        req.en_mask   = 8'hff;
        req.rs1_valid = 1'b0;
        valid         = 1'b1;
        k             = pick(7);
        case (p)
            0: req.op = op_t'(4'(k + 1));                   // add .. min
            1: req.op = op_t'(4'((k == 0) ? 0 : k + 7));    // mv, shifts, logic
            2: begin
                req.op        = op_t'(4'(pick(14)));
                req.rs1_valid = 1'b1;
            end
            default: begin
                req.op        = op_t'(4'(pick(16)));        // undefined codes too
                req.rs1_valid = pick(2);
                req.en_mask   = 8'(pick(256));
                if (p == 4)
                    valid = (pick(3) != 0);                 // idle gaps
            end
        endcase
    endtask

    initial begin
        logic         v_valid;
        vec_alu_req_t v_req;
        i_reset = 1'b1;
        i_valid = 1'b0;
        i_req   = '0;
        repeat (RESET_CYCLES) @(posedge i_clk);
        i_reset <= 1'b0;
        for (int p = 0; p < NUM_PHASES; p++) begin
            for (int c = 0; c < PHASE_CYCLES; c++) begin
                make_req(p, v_valid, v_req);
                @(posedge i_clk);
                i_valid <= v_valid;
                i_req   <= v_req;
                if (v_valid) begin
                    exp_q.push_back(model_result(v_req));
                    name_q.push_back(phase_name(p));
                end
            end
        end
        @(posedge i_clk);
        i_valid <= 1'b0;
        for (int w = 0; w < 8 && exp_q.size() != 0; w++) begin
            @(negedge i_clk);
        end
        repeat (4) @(negedge i_clk);                        // o_valid must stay low
        if (exp_q.size() != 0) begin
            $display("%0d expected results never came out", exp_q.size());
            err_other++;
        end
        $display("errors: %0d value mismatches, %0d other failures", err_value, err_other);
        if (err_value + err_other == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

    // --------------------------------------------------
    // output monitor sampled mid-cycle
    // --------------------------------------------------
    always @(negedge i_clk) begin
        if (cycle_cnt > 0) begin
            check_value("valid_timing", 64'(valid_d2), 64'(o_valid));
            if (o_valid === 1'b1) begin
                if (exp_q.size() == 0) begin
                    $display("o_valid went high with no request outstanding");
                    err_other++;
                end else begin
                    check_value(name_q.pop_front(), exp_q.pop_front(), o_res);
                end
            end
        end
        valid_d2 = valid_d1;
        valid_d1 = i_valid;                                 // taken at the next edge
    end

    always @(posedge i_clk) begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("errors: %0d value mismatches, %0d other failures", err_value, err_other);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

endmodule

/* vec_alu/vec_alu_top.sv */
// vector ALU top, two-stage pipeline around the arithmetic and shift/logic lanes
`timescale 1ns/1ps

module vec_alu_top (
    input  logic                     i_clk,
    input  logic                     i_reset,
    input  logic                     i_valid,
    input  vec_op_pkg::vec_alu_req_t i_req,
    output logic                     o_valid,
    output vec_types_pkg::vec_data_t o_res
);
    import vec_types_pkg::*;
    import vec_op_pkg::*;

    logic          w_ex1_valid;  // operands registered
    vec_operands_t w_ex1_opr;
    vec_data_t     w_arith_res;
    vec_data_t     w_shlog_res;

    // --------------------------------------------------
    // ex0
    // --------------------------------------------------
    vec_operand_stage vec_operand_stage_inst (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_valid (i_valid),
        .i_req   (i_req),
        .o_valid (w_ex1_valid),
        .o_opr   (w_ex1_opr)
    );

    // --------------------------------------------------
    // ex1, both lanes in parallel
    // --------------------------------------------------
    vec_arith_lane vec_arith_lane_inst (
        .i_opr (w_ex1_opr),
        .o_res (w_arith_res)
    );

    vec_shift_logic_lane vec_shift_logic_lane_inst (
        .i_opr (w_ex1_opr),
        .o_res (w_shlog_res)
    );

    vec_mask_merge vec_mask_merge_inst (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_valid     (w_ex1_valid),
        .i_opr       (w_ex1_opr),
        .i_arith_res (w_arith_res),
        .i_shlog_res (w_shlog_res),
        .o_valid     (o_valid),
        .o_res       (o_res)
    );

endmodule

/* vec_alu/vec_arith_lane.sv */
// arithmetic lane of the vector ALU, per-element add, subtract and max/min
`timescale 1ns/1ps

module vec_arith_lane (
    input  vec_op_pkg::vec_operands_t i_opr,
    output vec_types_pkg::vec_data_t  o_res
);
    import vec_types_pkg::*;
    import vec_op_pkg::*;

    // One element at any width. Both operands arrive zero-extended, with their
    // element sign bits beside them. The caller keeps only the element bits,
    // so sums wrap inside the element.
    function automatic logic [63:0] f_elem(
        input op_t         op,
        input logic [63:0] a,
        input logic [63:0] b,
        input logic        sa,
        input logic        sb
    );
        logic ltu;
        logic lts;
        ltu = b < a;                  // vs2 below opa, unsigned
        lts = (sa != sb) ? sb : ltu;  // equal signs order like unsigned
        case (op)
            OP_ADD:  f_elem = b + a;
            OP_SUB:  f_elem = b - a;
            OP_RSUB: f_elem = a - b;
            OP_MAXU: f_elem = ltu ? a : b;
            OP_MAX:  f_elem = lts ? a : b;
            OP_MINU: f_elem = ltu ? b : a;
            OP_MIN:  f_elem = lts ? b : a;
            default: f_elem = '0;  // not an arith op
        endcase
    endfunction

    // --------------------------------------------------
    // element loops per width
    // --------------------------------------------------
    always_comb begin
        logic [63:0] v_r;
        o_res = '0;
        v_r   = '0;
        unique case (i_opr.sew)
            EW8: begin
                for (int e = 0; e < 8; e++) begin
                    v_r = f_elem(i_opr.op, 64'(i_opr.opa.w8[e]), 64'(i_opr.vs2.w8[e]),
                                 i_opr.opa.w8[e][7], i_opr.vs2.w8[e][7]);
                    o_res.w8[e] = v_r[7:0];
                end
            end
            EW16: begin
                for (int e = 0; e < 4; e++) begin
                    v_r = f_elem(i_opr.op, 64'(i_opr.opa.w16[e]), 64'(i_opr.vs2.w16[e]),
                                 i_opr.opa.w16[e][15], i_opr.vs2.w16[e][15]);
                    o_res.w16[e] = v_r[15:0];
                end
            end
            EW32: begin
                for (int e = 0; e < 2; e++) begin
                    v_r = f_elem(i_opr.op, 64'(i_opr.opa.w32[e]), 64'(i_opr.vs2.w32[e]),
                                 i_opr.opa.w32[e][31], i_opr.vs2.w32[e][31]);
                    o_res.w32[e] = v_r[31:0];
                end
            end
            EW64: begin
                v_r = f_elem(i_opr.op, i_opr.opa.w64[0], i_opr.vs2.w64[0],
                             i_opr.opa.w64[0][63], i_opr.vs2.w64[0][63]);
                o_res.w64[0] = v_r;
            end
        endcase
    end

endmodule

/* vec_alu/vec_mask_merge.sv */
// ex1 stage of the vector ALU that selects a lane, merges under the mask and registers the result
`timescale 1ns/1ps

module vec_mask_merge (
    input  logic                      i_clk,
    input  logic                      i_reset,
    input  logic                      i_valid,
    input  vec_op_pkg::vec_operands_t i_opr,
    input  vec_types_pkg::vec_data_t  i_arith_res,
    input  vec_types_pkg::vec_data_t  i_shlog_res,
    output logic                      o_valid,
    output vec_types_pkg::vec_data_t  o_res
);
    import vec_types_pkg::*;
    import vec_op_pkg::*;

    vec_data_t w_sel;
    vec_data_t w_merged;

    always_comb begin
        case (i_opr.cls)
            CLS_ARITH: w_sel = i_arith_res;
            CLS_SHLOG: w_sel = i_shlog_res;
            default:   w_sel = '0;  // undefined opcode
        endcase
    end

    // --------------------------------------------------
    // element merge with upper mask bits unused at wide sew
    // --------------------------------------------------
    always_comb begin
        w_merged = '0;
        unique case (i_opr.sew)
            EW8: begin
                for (int e = 0; e < 8; e++) begin
                    w_merged.w8[e] = i_opr.en_mask[e] ? w_sel.w8[e] : i_opr.wr_old.w8[e];
                end
            end
            EW16: begin
                for (int e = 0; e < 4; e++) begin
                    w_merged.w16[e] = i_opr.en_mask[e] ? w_sel.w16[e] : i_opr.wr_old.w16[e];
                end
            end
            EW32: begin
                for (int e = 0; e < 2; e++) begin
                    w_merged.w32[e] = i_opr.en_mask[e] ? w_sel.w32[e] : i_opr.wr_old.w32[e];
                end
            end
            EW64: w_merged.w64[0] = i_opr.en_mask[0] ? w_sel.w64[0] : i_opr.wr_old.w64[0];
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            o_res <= w_merged;
        end
    end

    a_res_known: assert property (@(posedge i_clk) disable iff (i_reset)
        o_valid |-> !$isunknown(o_res.w64[0]));

endmodule

/* vec_alu/vec_operand_stage.sv */
// ex0 stage of the vector ALU, decodes the op class, splats the scalar and registers operands
`timescale 1ns/1ps

module vec_operand_stage (
    input  logic                      i_clk,
    input  logic                      i_reset,
    input  logic                      i_valid,
    input  vec_op_pkg::vec_alu_req_t  i_req,
    output logic                      o_valid,
    output vec_op_pkg::vec_operands_t o_opr
);
    import vec_types_pkg::*;
    import vec_op_pkg::*;

    vec_data_t     w_splat;
    op_class_t     w_cls;
    vec_operands_t w_opr;

    // --------------------------------------------------
    // decode
    // --------------------------------------------------
    always_comb begin
        case (i_req.op)
            OP_ADD, OP_SUB, OP_RSUB,
            OP_MAXU, OP_MAX, OP_MINU, OP_MIN:  w_cls = CLS_ARITH;
            OP_MV, OP_SLL, OP_SRL, OP_SRA,
            OP_AND, OP_OR, OP_XOR:             w_cls = CLS_SHLOG;
            default:                           w_cls = CLS_NONE;  // codes 14, 15
        endcase
    end

    // scalar copied into every element of the selected width
    always_comb begin
        w_splat = '0;
        unique case (i_req.sew)
            EW8:  for (int e = 0; e < 8; e++) w_splat.w8[e]  = i_req.rs1[7:0];
            EW16: for (int e = 0; e < 4; e++) w_splat.w16[e] = i_req.rs1[15:0];
            EW32: for (int e = 0; e < 2; e++) w_splat.w32[e] = i_req.rs1[31:0];
            EW64: w_splat.w64[0] = i_req.rs1;
        endcase
    end

    always_comb begin
        w_opr.op      = i_req.op;
        w_opr.cls     = w_cls;
        w_opr.sew     = i_req.sew;
        w_opr.opa     = i_req.rs1_valid ? w_splat : i_req.vs1;  // scalar wins
        w_opr.vs2     = i_req.vs2;
        w_opr.wr_old  = i_req.wr_old;
        w_opr.en_mask = i_req.en_mask;
    end

    // --------------------------------------------------
    // ex0/ex1 register
    // --------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            o_opr <= w_opr;  // held while idle
        end
    end

    a_op_known: assert property (@(posedge i_clk) disable iff (i_reset)
        i_valid |-> !$isunknown(i_req.op));

endmodule

/* vec_alu/vec_shift_logic_lane.sv */
// shift and logic lane of the vector ALU, per-element shifts, bitwise ops and move
`timescale 1ns/1ps

module vec_shift_logic_lane (
    input  vec_op_pkg::vec_operands_t i_opr,
    output vec_types_pkg::vec_data_t  o_res
);
    import vec_types_pkg::*;
    import vec_op_pkg::*;

    // One element shifted at any width. bz and bs are vs2 zero- and
    // sign-extended, sh is already cut down to log2 of the element width.
    function automatic logic [63:0] f_shift(
        input op_t         op,
        input logic [63:0] bz,
        input logic [63:0] bs,
        input logic [5:0]  sh
    );
        case (op)
            OP_SLL:  f_shift = bz << sh;
            OP_SRL:  f_shift = bz >> sh;
            OP_SRA:  f_shift = $signed(bs) >>> sh;  // fill from element sign
            default: f_shift = '0;
        endcase
    endfunction

    always_comb begin
        logic [63:0] v_r;
        o_res = '0;
        v_r   = '0;
        case (i_opr.op)
            // --------------------------------------------------
            // whole-word ops, element split makes no difference
            // --------------------------------------------------
            OP_MV:  o_res = i_opr.opa;
            OP_AND: o_res.w64[0] = i_opr.vs2.w64[0] & i_opr.opa.w64[0];
            OP_OR:  o_res.w64[0] = i_opr.vs2.w64[0] | i_opr.opa.w64[0];
            OP_XOR: o_res.w64[0] = i_opr.vs2.w64[0] ^ i_opr.opa.w64[0];
            // --------------------------------------------------
            // shifts per element
            // --------------------------------------------------
            OP_SLL, OP_SRL, OP_SRA: begin
                unique case (i_opr.sew)
                    EW8: begin
                        for (int e = 0; e < 8; e++) begin
                            v_r = f_shift(i_opr.op, 64'(i_opr.vs2.w8[e]),
                                          64'($signed(i_opr.vs2.w8[e])),
                                          {3'b000, i_opr.opa.w8[e][2:0]});
                            o_res.w8[e] = v_r[7:0];
                        end
                    end
                    EW16: begin
                        for (int e = 0; e < 4; e++) begin
                            v_r = f_shift(i_opr.op, 64'(i_opr.vs2.w16[e]),
                                          64'($signed(i_opr.vs2.w16[e])),
                                          {2'b00, i_opr.opa.w16[e][3:0]});
                            o_res.w16[e] = v_r[15:0];
                        end
                    end
                    EW32: begin
                        for (int e = 0; e < 2; e++) begin
                            v_r = f_shift(i_opr.op, 64'(i_opr.vs2.w32[e]),
                                          64'($signed(i_opr.vs2.w32[e])),
                                          {1'b0, i_opr.opa.w32[e][4:0]});
                            o_res.w32[e] = v_r[31:0];
                        end
                    end
                    EW64: begin
                        v_r = f_shift(i_opr.op, i_opr.vs2.w64[0], i_opr.vs2.w64[0],
                                      i_opr.opa.w64[0][5:0]);
                        o_res.w64[0] = v_r;
                    end
                endcase
            end
            default: o_res = '0;  // arith or undefined
        endcase
    end

endmodule

/* vlog.f */
+incdir+common
+incdir+test
common/vec_types_pkg.sv
common/vec_op_pkg.sv
vec_alu/vec_operand_stage.sv
vec_alu/vec_arith_lane.sv
vec_alu/vec_shift_logic_lane.sv
vec_alu/vec_mask_merge.sv
vec_alu/vec_alu_top.sv
test/tb_vec_alu.sv
